/* verilog/mem_data_pkg.sv */
/*
  word and byte-enable types shared by the memory and its bench
  word width must stay a multiple of 8, one enable bit per byte
*/

package mem_data_pkg;

  // width of one memory word as seen on the port
  localparam int unsigned DataWidth = 32;

  // bits covered by a single byte enable
  localparam int unsigned ByteWidth = 8;

  localparam int unsigned BeWidth = DataWidth / ByteWidth;  // one enable per byte

  // read and write data word
  typedef logic [DataWidth-1:0] data_t;

  // per-byte write enable, bit 0 covers data bits 7:0
  typedef logic [BeWidth-1:0] be_t;

endpackage

/* verilog/mem_geom_pkg.sv */
/*
  default geometry of the banked memory
  BankWords is fixed by the modeled 1024x32 macro, bank count is free
*/

package mem_geom_pkg;

  // depth of one hard macro in words
  localparam int unsigned BankWords = 1024;

  // macros stacked behind one flat address
  localparam int unsigned DefaultNumBanks = 8;

  // total depth of the default build, 8192 words
  localparam int unsigned DefaultNumWords = BankWords * DefaultNumBanks;

  // the top level takes these only as parameter defaults,
  // any other power-of-two NumWords and NumBanks may be set there

endpackage

/* verilog/bank_decoder.sv */
/*
  NumWords and NumBanks must be powers of two, NumBanks at least 2
  chip selects are combinational, read bank index changes on read edges only
*/

`timescale 1ns/1ps

module bank_decoder #(
  parameter int unsigned NumWords = mem_geom_pkg::DefaultNumWords,
  parameter int unsigned NumBanks = mem_geom_pkg::DefaultNumBanks
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [AddrWidth-1:BankAddrWidth]  bank_addr_i,  // upper address bits
  output logic [NumBanks-1:0]               csb_o,        // active low, one per bank
  output logic [BankSelWidth-1:0]           rd_bank_o
);

  localparam int unsigned AddrWidth     = $clog2(NumWords);
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);
  localparam int unsigned BankAddrWidth = AddrWidth - BankSelWidth;

  logic [BankSelWidth-1:0] bank_sel;
  logic [BankSelWidth-1:0] rd_bank_q;

  assign bank_sel = bank_addr_i;  // renumber to start at bit 0

  // one bank selected per request, none when idle
  always_comb
  begin
    csb_o = '1;
    if (req_i)
    begin
      csb_o[bank_sel] = 1'b0;
    end
  end

  // writes leave the pointer alone, the read bank still holds its output
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_bank_q <= '0;
    end
    else if (req_i && !we_i)
    begin
      rd_bank_q <= bank_sel;
    end
  end

  assign rd_bank_o = rd_bank_q;

endmodule

/* verilog/sram_bank.sv */
/*
  behavioral stand-in for a 1rw hard macro, no timing and no spare bit
  array contents are undefined after reset, only the output register clears
*/

`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned NumWords = mem_geom_pkg::BankWords  // depth of this bank
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   csb_i,    // chip select, active low
  input  logic                   web_i,    // write enable, active low
  input  mem_data_pkg::be_t      wmask_i,  // byte write mask
  input  logic [AddrWidth-1:0]   addr_i,
  input  mem_data_pkg::data_t    din_i,
  output mem_data_pkg::data_t    dout_o
);

  localparam int unsigned AddrWidth = $clog2(NumWords);
  localparam int unsigned ByteWidth = mem_data_pkg::ByteWidth;

  mem_data_pkg::data_t mem_q [NumWords];
  mem_data_pkg::data_t dout_q;

  logic wr_en;
  logic rd_en;

  assign wr_en = !csb_i && !web_i;
  assign rd_en = !csb_i && web_i;

  // masked write, bytes with a clear mask bit keep their old value
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < mem_data_pkg::BeWidth; b++)
      begin
        if (wmask_i[b])
        begin
          mem_q[addr_i][ByteWidth*b +: ByteWidth] <= din_i[ByteWidth*b +: ByteWidth];
        end
      end
    end
  end

  // output latch of the macro
  // it only moves on a read, so the last read word stays visible
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dout_q <= '0;
    end
    else if (rd_en)
    begin
      dout_q <= mem_q[addr_i];
    end
  end

  assign dout_o = dout_q;

endmodule

/* verilog/bank_read_mux.sv */
/*
  combinational drain of the bank outputs, no pipeline stage
  rd_bank_i must come from the decoder so it tracks the last read
*/

`timescale 1ns/1ps

module bank_read_mux #(
  parameter int unsigned NumBanks = mem_geom_pkg::DefaultNumBanks
) (
  input  mem_data_pkg::data_t     bank_dout_i [NumBanks],
  input  logic [BankSelWidth-1:0] rd_bank_i,
  output mem_data_pkg::data_t     rdata_o
);

  localparam int unsigned BankSelWidth = $clog2(NumBanks);

  logic [NumBanks-1:0] sel_oh;

  // expand the index so the mux becomes a plain and-or tree
  always_comb
  begin
    sel_oh = '0;
    sel_oh[rd_bank_i] = 1'b1;
  end

  always_comb
  begin
    rdata_o = '0;
    for (int i = 0; i < NumBanks; i++)
    begin
      rdata_o = rdata_o | (bank_dout_i[i] & {mem_data_pkg::DataWidth{sel_oh[i]}});
    end
  end

endmodule

/* verilog/banked_sram.sv */
/*
  flat single-port memory built from NumBanks equal macros
  one request per cycle, no stall, read data valid one cycle after the request
  NumWords and NumBanks must be powers of two with NumBanks at least 2
*/

`timescale 1ns/1ps

module banked_sram #(
  parameter int unsigned NumWords = mem_geom_pkg::DefaultNumWords,
  parameter int unsigned NumBanks = mem_geom_pkg::DefaultNumBanks
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,    // request, taken on every edge it is high
  input  logic                  we_i,     // 1 write, 0 read
  input  logic [AddrWidth-1:0]  addr_i,   // flat word address
  input  mem_data_pkg::data_t   wdata_i,
  input  mem_data_pkg::be_t     be_i,     // only used on writes
  output mem_data_pkg::data_t   rdata_o
);

  localparam int unsigned AddrWidth     = $clog2(NumWords);
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);
  localparam int unsigned BankAddrWidth = AddrWidth - BankSelWidth;
  localparam int unsigned BankDepth     = NumWords / NumBanks;

  logic [NumBanks-1:0]      csb;
  logic [BankSelWidth-1:0]  rd_bank;
  logic                     web;
  logic [BankAddrWidth-1:0] bank_addr;  // word offset inside a bank

  mem_data_pkg::data_t bank_dout [NumBanks];

  assign web       = ~we_i;  // macros take an active low write enable
  assign bank_addr = addr_i[BankAddrWidth-1:0];

  // upper address bits pick the bank
  bank_decoder #(
    .NumWords (NumWords),
    .NumBanks (NumBanks)
  ) bank_decoder_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .bank_addr_i (addr_i[AddrWidth-1:BankAddrWidth]),
    .csb_o       (csb),
    .rd_bank_o   (rd_bank)
  );

  // all banks share address, data and mask, only csb differs
  for (genvar i = 0; i < NumBanks; i++)
  begin : gen_bank
    sram_bank #(
      .NumWords (BankDepth)
    ) sram_bank_i (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .csb_i    (csb[i]),
      .web_i    (web),
      .wmask_i  (be_i),
      .addr_i   (bank_addr),
      .din_i    (wdata_i),
      .dout_o   (bank_dout[i])
    );
  end

  bank_read_mux #(
    .NumBanks (NumBanks)
  ) bank_read_mux_i (
    .bank_dout_i (bank_dout),
    .rd_bank_i   (rd_bank),
    .rdata_o     (rdata_o)
  );

endmodule

/* bench/tb_clkgen.sv */
/*
  free running clock, reset released on a falling edge after the reset cycles
*/

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned HalfPeriod  = 4,  // ns, 8 ns period
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial
  begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);  // away from the active edge
    arst_n_o = 1'b1;
  end

endmodule

/* bench/tb_checker.sv */
/*
  compares rdata against the expected word whenever the compare strobe is high
  strobe and expected value must arrive one cycle after the request edge
*/

`timescale 1ns/1ps

module tb_checker (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                cmp_i,     // compare this cycle
  input  mem_data_pkg::data_t exp_i,
  input  mem_data_pkg::data_t rdata_i,
  output int                  pass_cnt_o,
  output int                  err_cnt_o
);

  // sampled at the edge, so rdata is the value settled after the request edge
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pass_cnt_o <= 0;
      err_cnt_o  <= 0;
    end
    else if (cmp_i)
    begin
      if (rdata_i !== exp_i)
      begin
        $display("error at %0t ns: rdata_o expected %h actual %h",
                 $time, exp_i, rdata_i);
        err_cnt_o <= err_cnt_o + 1;
      end
      else
      begin
        pass_cnt_o <= pass_cnt_o + 1;
      end
    end
  end

endmodule

/* bench/tb_banked_sram.sv */
/*
  table driven test of banked_sram with default geometry
  expected values come from a reference array built while the table is filled
*/

`timescale 1ns/1ps

module tb_banked_sram;

  localparam int unsigned AddrWidth = $clog2(mem_geom_pkg::DefaultNumWords);
  localparam logic [1:0]  OpIdle = 2'd0;
  localparam logic [1:0]  OpWrite = 2'd1;
  localparam logic [1:0]  OpRead = 2'd2;
  localparam int          ResetTimeout = 20;
  localparam int          CheckTimeout = 10;  // cycles for the checker to catch up
  localparam int          NumRand = 24;

  typedef struct packed {
    logic [1:0]           op;
    logic [AddrWidth-1:0] addr;
    mem_data_pkg::data_t  wdata;
    mem_data_pkg::be_t    be;
    logic                 chk;   // compare rdata after this entry
    mem_data_pkg::data_t  exp;
  } entry_t;

  logic clk, arst_n, req, we, cmp;
  logic [AddrWidth-1:0] addr;
  mem_data_pkg::data_t wdata, rdata, exp;
  mem_data_pkg::be_t be;
  int pass_cnt, err_cnt, total_chk;
  logic timed_out;
  logic [31:0] lfsr_q;

  entry_t tbl [$];
  int grp_first [$];
  int grp_last [$];
  string grp_name [$];
  mem_data_pkg::data_t ref_mem [logic [AddrWidth-1:0]];
  mem_data_pkg::data_t last_rd;  // what rdata_o should hold
  logic [AddrWidth-1:0] last_rd_addr;

  tb_clkgen clkgen_i (.clk_o(clk), .arst_n_o(arst_n));

  banked_sram dut_i (
    .clk_i(clk), .arst_n_i(arst_n), .req_i(req), .we_i(we),
    .addr_i(addr), .wdata_i(wdata), .be_i(be), .rdata_o(rdata)
  );

  tb_checker checker_i (
    .clk_i(clk), .arst_n_i(arst_n), .cmp_i(cmp), .exp_i(exp),
    .rdata_i(rdata), .pass_cnt_o(pass_cnt), .err_cnt_o(err_cnt)
  );

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // new bytes where be is set and old bytes elsewhere
  function automatic mem_data_pkg::data_t merge_bytes(input mem_data_pkg::data_t old_w,
      input mem_data_pkg::data_t new_w, input mem_data_pkg::be_t en);
    mem_data_pkg::data_t r;
    r = old_w;
    for (int k = 0; k < mem_data_pkg::BeWidth; k++)
    begin
      if (en[k])
      begin
        r[8*k +: 8] = new_w[8*k +: 8];
      end
    end
    return r;
  endfunction

  task automatic add_write(input logic [AddrWidth-1:0] a, input mem_data_pkg::data_t d,
      input mem_data_pkg::be_t en, input logic chk);
    entry_t e;
    mem_data_pkg::data_t old_w;
    old_w = ref_mem.exists(a) ? ref_mem[a] : '0;
    ref_mem[a] = merge_bytes(old_w, d, en);
    e = '{op: OpWrite, addr: a, wdata: d, be: en, chk: chk, exp: last_rd};
    tbl.push_back(e);
  endtask

  task automatic add_read(input logic [AddrWidth-1:0] a);
    entry_t e;
    last_rd = ref_mem[a];
    last_rd_addr = a;
    e = '{op: OpRead, addr: a, wdata: '0, be: '0, chk: 1'b1, exp: last_rd};
    tbl.push_back(e);
  endtask

  // idle keeps the last read address on the bus so a stray bank read shows up
  task automatic add_idle(input logic chk);
    entry_t e;
    e = '{op: OpIdle, addr: last_rd_addr, wdata: '0, be: '0, chk: chk, exp: last_rd};
    tbl.push_back(e);
  endtask

  task automatic open_group(input string name);
    grp_first.push_back(tbl.size());
    grp_name.push_back(name);
  endtask

  task automatic close_group();
    grp_last.push_back(tbl.size() - 1);
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [AddrWidth-1:0] rnd_addr [NumRand];
    last_rd = '0;  // output registers clear on reset
    last_rd_addr = '0;
    open_group("reset value");
    add_idle(1'b1);
    add_idle(1'b1);
    close_group();
    open_group("full word write and read");
    add_write(13'h0123, 32'ha5a5_5a5a, 4'hf, 1'b0);
    add_read(13'h0123);
    add_write(13'h1f00, 32'h0bad_cafe, 4'hf, 1'b0);
    add_read(13'h1f00);
    close_group();
    open_group("byte masking");
    for (int p = 0; p < 16; p++)
    begin
      add_write(13'h0456, 32'hffff_ffff, 4'hf, 1'b0);
      add_write(13'h0456, 32'h1234_5600 | p, p[3:0], 1'b0);
      add_read(13'h0456);
    end
    close_group();
    open_group("bank isolation");
    for (int b = 0; b < 8; b++)
    begin
      add_write({b[2:0], 10'h2a7}, 32'hb000_0000 | (b * 32'h0011_0101), 4'hf, 1'b0);
    end
    for (int b = 0; b < 8; b++)
    begin
      add_read({b[2:0], 10'h2a7});
    end
    close_group();
    open_group("read data hold");
    add_write({3'd3, 10'h011}, 32'h3333_0011, 4'hf, 1'b0);
    add_read({3'd3, 10'h011});
    add_write({3'd5, 10'h011}, 32'h5555_0011, 4'hf, 1'b1);  // other bank
    add_idle(1'b1);
    add_write({3'd3, 10'h011}, 32'h3333_9999, 4'hf, 1'b1);  // same word but output stays
    add_idle(1'b1);
    add_read({3'd3, 10'h011});
    add_idle(1'b1);
    close_group();
    open_group("random write then read");
    for (int i = 0; i < NumRand; i++)
    begin
      take_bits(AddrWidth, v);
      rnd_addr[i] = v[AddrWidth-1:0];
      if (i % 6 == 5)
      begin
        rnd_addr[i] = rnd_addr[i-3];  // force an overwrite
      end
      take_bits(32, v);
      add_write(rnd_addr[i], v, 4'hf, 1'b0);
    end
    for (int i = 0; i < NumRand; i++)
    begin
      add_read(rnd_addr[i]);
    end
    close_group();
  endtask

  // entries go out on rising edges and the expected value trails by one cycle
  task automatic run_group(input int first, input int last, input string name);
    int err_before, done_before, chk_count, wait_cycles;
    logic prev_chk;
    mem_data_pkg::data_t prev_exp;
    err_before = err_cnt;
    done_before = pass_cnt + err_cnt;
    chk_count = 0;
    prev_chk = 1'b0;
    prev_exp = '0;
    for (int i = first; i <= last; i++)
    begin
      @(posedge clk);
      req   <= (tbl[i].op != OpIdle);
      we    <= (tbl[i].op == OpWrite);
      addr  <= tbl[i].addr;
      wdata <= tbl[i].wdata;
      be    <= tbl[i].be;
      cmp   <= prev_chk;
      exp   <= prev_exp;
      prev_chk = tbl[i].chk;
      prev_exp = tbl[i].exp;
      chk_count += tbl[i].chk ? 1 : 0;
    end
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    cmp <= prev_chk;
    exp <= prev_exp;
    @(posedge clk);
    cmp <= 1'b0;
    total_chk += chk_count;
    wait_cycles = 0;
    while (pass_cnt + err_cnt < done_before + chk_count && wait_cycles < CheckTimeout)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (pass_cnt + err_cnt < done_before + chk_count)
    begin
      $display("timeout: checker finished %0d of %0d compares in test %s",
               pass_cnt + err_cnt - done_before, chk_count, name);
      timed_out = 1'b1;
    end
    else
    begin
      $display("test %s: %0d checks, %0d errors", name, chk_count, err_cnt - err_before);
    end
  endtask

  initial
  begin : main_flow
    int cyc;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    be = '0;
    cmp = 1'b0;
    exp = '0;
    total_chk = 0;
    timed_out = 1'b0;
    lfsr_q = 32'h1c58_83ac;
    build_table();
    cyc = 0;
    while (arst_n !== 1'b1 && cyc < ResetTimeout)
    begin
      @(posedge clk);
      cyc++;
    end
    if (arst_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end
    for (int g = 0; g < grp_name.size(); g++)
    begin
      if (!timed_out)
      begin
        run_group(grp_first[g], grp_last[g], grp_name[g]);
      end
    end
    $display("checks: %0d passed, %0d failed, %0d expected", pass_cnt, err_cnt, total_chk);
    if (!timed_out && err_cnt == 0 && pass_cnt == total_chk)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* banked_sram.f */
verilog/mem_data_pkg.sv
verilog/mem_geom_pkg.sv
verilog/bank_decoder.sv
verilog/sram_bank.sv
verilog/bank_read_mux.sv
verilog/banked_sram.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_banked_sram.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the banked_sram testbench with Verilator
# exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing \
  -f banked_sram.f \
  --top-module tb_banked_sram \
  --Mdir "$OBJ" \
  -o tb_banked_sram_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$OBJ/tb_banked_sram_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
